/* filelist.f */
design/ahb_pkg.sv
design/cache_pkg.sv
design/ahb_src_port.sv
design/cache_ctrl.sv
design/cache_mem.sv
design/ahb_dst_port.sv
design/ahb_cache_wb.sv
bench/tb_ahb_cache_wb.sv

/* Bender.yml */
package:
  name: ahb_cache_wb

sources:
  - files:
      - design/ahb_pkg.sv
      - design/cache_pkg.sv
      - design/ahb_src_port.sv
      - design/cache_ctrl.sv
      - design/cache_mem.sv
      - design/ahb_dst_port.sv
      - design/ahb_cache_wb.sv
  - target: simulation
    files:
      - bench/tb_ahb_cache_wb.sv

/* bench/tb_ahb_cache_wb.sv */
// -------------------------------------------------------------------
// Testbench for the write-back cache, with a downstream memory model,
// a byte-level shadow reference and a pipelined upstream master
// -------------------------------------------------------------------
module tb_ahb_cache_wb;
	import ahb_pkg::*;

	localparam int MAX_WAIT       = 3;
	localparam int N_RANDOM       = 400;
	localparam int N_XFERS        = 1 + 14 + 3 + 6 + N_RANDOM;
	// Write-back plus fill at full wait, then check, modify and done
	localparam int WORST_MISS     = 2 * (MAX_WAIT + 1) + 4;
	localparam int TIMEOUT_CYCLES = N_XFERS * WORST_MISS + 200;
	localparam int N_BYTES        = 4096;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       src_hready;
	addr_t      src_haddr;
	logic       src_hwrite;
	logic [1:0] src_htrans;
	size_t      src_hsize;
	data_t      src_hwdata;
	logic       src_hready_resp;
	data_t      src_hrdata;
	addr_t      dst_haddr;
	logic       dst_hwrite;
	logic [1:0] dst_htrans;
	size_t      dst_hsize;
	data_t      dst_hwdata;
	logic       dst_hready;
	logic       dst_hready_resp;
	data_t      dst_hrdata;

	integer seed = 32'h4392a9c2;
	int     errors = 0;
	int     checks = 0;
	int     err_mark = 0;
	int     cycles = 0;
	int     fill_count = 0;

	// Pending upstream transfers, pushed by the tests
	addr_t q_addr [$];
	logic  q_write [$];
	size_t q_size [$];
	data_t q_data [$];

	// Transfer on the address bus and the one in its data phase
	logic  ap_valid = 1'b0;
	addr_t ap_addr;
	logic  ap_write;
	size_t ap_size;
	data_t ap_data;
	logic  dp_valid = 1'b0;
	addr_t dp_addr;
	logic  dp_write;
	size_t dp_size;
	data_t dp_data;
	logic  hready_s;

	logic [7:0] shadow [0:N_BYTES-1];
	data_t      mem_words [0:N_BYTES/4-1];

	always #20 clk = ~clk;

	// Single slave on the upstream bus
	assign src_hready = src_hready_resp;

	ahb_cache_wb u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.src_hready      (src_hready),
		.src_haddr       (src_haddr),
		.src_hwrite      (src_hwrite),
		.src_htrans      (src_htrans),
		.src_hsize       (src_hsize),
		.src_hwdata      (src_hwdata),
		.src_hready_resp (src_hready_resp),
		.src_hrdata      (src_hrdata),
		.dst_haddr       (dst_haddr),
		.dst_hwrite      (dst_hwrite),
		.dst_htrans      (dst_htrans),
		.dst_hsize       (dst_hsize),
		.dst_hwdata      (dst_hwdata),
		.dst_hready      (dst_hready),
		.dst_hready_resp (dst_hready_resp),
		.dst_hrdata      (dst_hrdata)
	);

	// -------------------------------------------------------------------
	// Reference model

	// Power-up memory contents, mixed from every address bit
	function automatic data_t init_word(input addr_t a);
		return (a * 32'h9e37_79b9) ^ 32'h5bd1_e995;
	endfunction

	// Expected word, all earlier upstream writes already applied
	function automatic data_t ref_word(input addr_t a);
		int    base;
		data_t w;
		base = {a[11:2], 2'b00};
		for (int i = 0; i < N_LANES; i++)
			w[i*8 +: 8] = shadow[base + i];
		return w;
	endfunction

	// Only the lanes covered by size and offset change
	task automatic apply_write(input addr_t a, input size_t sz, input data_t d);
		int base;
		int lane;
		base = a[11:0];
		for (int i = 0; i < (1 << sz); i++) begin
			lane = (base + i) % N_LANES;
			shadow[base + i] = d[lane*8 +: 8];
		end
	endtask

	function automatic addr_t make_addr(input int tag, input int idx, input int off);
		return addr_t'((tag << (W_LANE_SEL + cache_pkg::W_INDEX)) | (idx << W_LANE_SEL) | off);
	endfunction

	// -------------------------------------------------------------------
	// Upstream master, pipelined, advances on hready

	always @(posedge clk) begin
		if (rst_n && hready_s) begin
			// Address phase moves into its data phase
			dp_valid = ap_valid;
			dp_addr  = ap_addr;
			dp_write = ap_write;
			dp_size  = ap_size;
			dp_data  = ap_data;
			if (ap_valid && ap_write)
				src_hwdata <= ap_data;
			if (q_addr.size() > 0) begin
				ap_valid = 1'b1;
				ap_addr  = q_addr.pop_front();
				ap_write = q_write.pop_front();
				ap_size  = q_size.pop_front();
				ap_data  = q_data.pop_front();
				src_htrans <= HTRANS_NSEQ;
				src_haddr  <= ap_addr;
				src_hwrite <= ap_write;
				src_hsize  <= ap_size;
			end else begin
				ap_valid = 1'b0;
				src_htrans <= HTRANS_IDLE;
			end
		end
	end

	// Compare process, data phases end on hready_resp
	always @(negedge clk) begin
		hready_s = src_hready_resp;
		if (rst_n && src_hready_resp && dp_valid) begin
			if (dp_write) begin
				apply_write(dp_addr, dp_size, dp_data);
			end else begin
				checks++;
				if (src_hrdata !== ref_word(dp_addr)) begin
					errors++;
					$display("mismatch at %0t: src_hrdata for %h got %h expected %h",
						$time, dp_addr, src_hrdata, ref_word(dp_addr));
				end
			end
		end
	end

	// -------------------------------------------------------------------
	// Downstream memory with random wait states

	logic       mem_ready_q = 1'b1;
	logic       mem_pend = 1'b0;
	logic       mem_pwrite;
	logic [9:0] mem_paddr;
	int         wait_left = 0;
	logic [31:0] mem_rnd;
	logic [1:0] dst_htrans_s;
	addr_t      dst_haddr_s;
	logic       dst_hwrite_s;
	size_t      dst_hsize_s;
	data_t      dst_hwdata_s;

	always @(negedge clk) begin
		dst_htrans_s = dst_htrans;
		dst_haddr_s  = dst_haddr;
		dst_hwrite_s = dst_hwrite;
		dst_hsize_s  = dst_hsize;
		dst_hwdata_s = dst_hwdata;
		// Bus hready follows the memory's own response
		if (rst_n && dst_hready !== dst_hready_resp) begin
			errors++;
			$display("mismatch at %0t: dst_hready got %b expected %b",
				$time, dst_hready, dst_hready_resp);
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			if (mem_ready_q) begin
				// Write data phase ends here
				if (mem_pend && mem_pwrite)
					mem_words[mem_paddr] = dst_hwdata_s;
				mem_pend = 1'b0;
				if (dst_htrans_s == HTRANS_NSEQ) begin
					if (dst_haddr_s[31:12] != 0 || dst_hsize_s != HSIZE_WORD) begin
						errors++;
						$display("downstream transfer at %0t is outside the memory or not a word",
							$time);
					end
					mem_pend   = 1'b1;
					mem_pwrite = dst_hwrite_s;
					mem_paddr  = dst_haddr_s[11:2];
					if (!dst_hwrite_s)
						fill_count++;
					mem_rnd   = $random(seed);
					wait_left = mem_rnd[1:0];
				end
			end else begin
				wait_left = wait_left - 1;
			end
			if (mem_pend && wait_left == 0) begin
				mem_ready_q = 1'b1;
				dst_hrdata <= mem_words[mem_paddr];
			end else begin
				mem_ready_q = !mem_pend;
			end
			dst_hready_resp <= mem_ready_q;
		end
	end

	// -------------------------------------------------------------------
	// Timeout

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the transfers did not complete", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// -------------------------------------------------------------------
	// Test helpers

	task automatic queue_xfer(input addr_t a, input logic wr, input size_t sz, input data_t d);
		q_addr.push_back(a);
		q_write.push_back(wr);
		q_size.push_back(sz);
		q_data.push_back(d);
	endtask

	// Until every queued transfer has ended
	task automatic wait_quiet();
		@(negedge clk);
		while (q_addr.size() > 0 || ap_valid || dp_valid)
			@(negedge clk);
	endtask

	task automatic finish_test(input string name);
		$display("test %s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// -------------------------------------------------------------------
	// Stimulus

	addr_t addr_a;
	addr_t addr_b;
	int    fills_before;
	int    sz;
	logic [31:0] rnd;

	initial begin
		rst_n           = 1'b0;
		src_haddr       = '0;
		src_hwrite      = 1'b0;
		src_htrans      = HTRANS_IDLE;
		src_hsize       = '0;
		src_hwdata      = '0;
		dst_hready_resp = 1'b1;
		dst_hrdata      = '0;
		for (int i = 0; i < N_BYTES / 4; i++) begin
			mem_words[i] = init_word(addr_t'(i * 4));
			for (int b = 0; b < N_LANES; b++)
				shadow[i*4 + b] = mem_words[i][b*8 +: 8];
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Reset state, then a cold read through a fill
		@(negedge clk);
		if (src_hready_resp !== 1'b1 || dst_htrans !== HTRANS_IDLE) begin
			errors++;
			$display("after reset hready_resp is not high or dst_htrans is not IDLE");
		end
		fills_before = fill_count;
		queue_xfer(make_addr(7, 50, 0), 1'b0, HSIZE_WORD, '0);
		wait_quiet();
		if (fill_count != fills_before + 1) begin
			errors++;
			$display("first read did not refill from the downstream memory");
		end
		finish_test("reset and cold read");

		// Every size at every legal offset, each read back
		for (int s = 0; s < 3; s++)
			for (int off = 0; off < N_LANES; off += (1 << s)) begin
				queue_xfer(make_addr(1, 20, off), 1'b1, size_t'(s), $random(seed));
				queue_xfer(make_addr(1, 20, 0), 1'b0, HSIZE_WORD, '0);
			end
		wait_quiet();
		finish_test("write sizes and lanes");

		// Same index, other tag, forces a dirty eviction
		addr_a = make_addr(5, 9, 0);
		addr_b = make_addr(6, 9, 0);
		queue_xfer(addr_a, 1'b1, HSIZE_WORD, 32'hcafe_f00d);
		queue_xfer(addr_b, 1'b0, HSIZE_WORD, '0);
		wait_quiet();
		if (mem_words[addr_a[11:2]] !== ref_word(addr_a)) begin
			errors++;
			$display("mismatch at %0t: mem_words[%h] got %h expected %h",
				$time, addr_a, mem_words[addr_a[11:2]], ref_word(addr_a));
		end
		queue_xfer(addr_a, 1'b0, HSIZE_WORD, '0);
		wait_quiet();
		finish_test("eviction");

		// Dirty write hits with a read right behind, through the stall state
		addr_a = make_addr(2, 33, 0);
		queue_xfer(addr_a, 1'b0, HSIZE_WORD, '0);
		queue_xfer(addr_a, 1'b1, HSIZE_WORD, 32'h1234_5678);
		queue_xfer(addr_a + 1, 1'b1, 3'd0, 32'h0000_ab00);
		queue_xfer(addr_a, 1'b0, HSIZE_WORD, '0);
		queue_xfer(addr_a + 2, 1'b1, 3'd1, 32'h9876_0000);
		queue_xfer(addr_a, 1'b0, HSIZE_WORD, '0);
		wait_quiet();
		finish_test("write then read stall");

		// Random mix over four indices and four tags
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd = $random(seed);
			sz  = (rnd[5:4] == 2'd3) ? 2 : rnd[5:4];
			if (rnd[8])
				queue_xfer(make_addr(rnd[3:2], rnd[1:0], rnd[7:6] & ~((1 << sz) - 1)),
					1'b1, size_t'(sz), $random(seed));
			else
				queue_xfer(make_addr(rnd[3:2], rnd[1:0], 0), 1'b0, HSIZE_WORD, '0);
		end
		wait_quiet();
		finish_test("random traffic");

		$display("%0d read checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* design/ahb_cache_wb.sv */
// -------------------------------------------------------------------
// Direct-mapped write-back cache between two AHB-Lite buses
// -------------------------------------------------------------------
module ahb_cache_wb (
	input  logic           clk,
	input  logic           rst_n,
	// Upstream slave
	input  logic           src_hready,
	input  ahb_pkg::addr_t src_haddr,
	input  logic           src_hwrite,
	input  logic [1:0]     src_htrans,
	input  ahb_pkg::size_t src_hsize,
	input  ahb_pkg::data_t src_hwdata,
	output logic           src_hready_resp,
	output ahb_pkg::data_t src_hrdata,
	// Downstream master
	output ahb_pkg::addr_t dst_haddr,
	output logic           dst_hwrite,
	output logic [1:0]     dst_htrans,
	output ahb_pkg::size_t dst_hsize,
	output ahb_pkg::data_t dst_hwdata,
	output logic           dst_hready,
	input  logic           dst_hready_resp,
	input  ahb_pkg::data_t dst_hrdata
);
	import ahb_pkg::*;
	import cache_pkg::*;

	logic         aphase_read;
	logic         aphase_write;
	addr_t        addr_dphase;
	lane_mask_t   lane_mask_dphase;
	cache_state_t state;
	index_t       t_index;
	tag_t         t_tag;
	logic         t_ren;
	logic         t_wen;
	logic         t_wvalid;
	logic         t_wdirty;
	index_t       d_index;
	logic         d_ren;
	lane_mask_t   d_wen;
	data_t        wdata;
	logic         hit;
	logic         dirty;
	addr_t        victim_addr;
	data_t        rdata;
	logic         dst_ready;
	logic         dphase_active;
	data_t        fill_rdata;

	// Write-back data comes straight off the data store
	assign dst_hwdata = rdata;

	ahb_src_port u_src_port (
		.clk              (clk),
		.rst_n            (rst_n),
		.src_hready       (src_hready),
		.src_htrans       (src_htrans),
		.src_hwrite       (src_hwrite),
		.src_haddr        (src_haddr),
		.src_hsize        (src_hsize),
		.aphase_read      (aphase_read),
		.aphase_write     (aphase_write),
		.addr_dphase      (addr_dphase),
		.lane_mask_dphase (lane_mask_dphase)
	);

	cache_ctrl u_ctrl (
		.clk              (clk),
		.rst_n            (rst_n),
		.aphase_read      (aphase_read),
		.aphase_write     (aphase_write),
		.addr_dphase      (addr_dphase),
		.lane_mask_dphase (lane_mask_dphase),
		.src_haddr        (src_haddr),
		.src_hwdata       (src_hwdata),
		.hit              (hit),
		.dirty            (dirty),
		.rdata            (rdata),
		.dst_ready        (dst_ready),
		.dphase_active    (dphase_active),
		.fill_rdata       (fill_rdata),
		.state            (state),
		.src_hready_resp  (src_hready_resp),
		.src_hrdata       (src_hrdata),
		.t_index          (t_index),
		.t_tag            (t_tag),
		.t_ren            (t_ren),
		.t_wen            (t_wen),
		.t_wvalid         (t_wvalid),
		.t_wdirty         (t_wdirty),
		.d_index          (d_index),
		.d_ren            (d_ren),
		.d_wen            (d_wen),
		.wdata            (wdata)
	);

	cache_mem u_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.t_index     (t_index),
		.t_tag       (t_tag),
		.t_ren       (t_ren),
		.t_wen       (t_wen),
		.t_wvalid    (t_wvalid),
		.t_wdirty    (t_wdirty),
		.d_index     (d_index),
		.d_ren       (d_ren),
		.d_wen       (d_wen),
		.wdata       (wdata),
		.hit         (hit),
		.dirty       (dirty),
		.victim_addr (victim_addr),
		.rdata       (rdata)
	);

	ahb_dst_port u_dst_port (
		.clk             (clk),
		.rst_n           (rst_n),
		.state           (state),
		.hit             (hit),
		.dirty           (dirty),
		.addr_dphase     (addr_dphase),
		.victim_addr     (victim_addr),
		.dst_hready_resp (dst_hready_resp),
		.dst_hrdata      (dst_hrdata),
		.dst_haddr       (dst_haddr),
		.dst_hwrite      (dst_hwrite),
		.dst_htrans      (dst_htrans),
		.dst_hsize       (dst_hsize),
		.dst_hready      (dst_hready),
		.dst_ready       (dst_ready),
		.dphase_active   (dphase_active),
		.fill_rdata      (fill_rdata)
	);

endmodule

/* design/ahb_dst_port.sv */
// -------------------------------------------------------------------
// Downstream AHB-Lite master side, single-word write-back and fill
// -------------------------------------------------------------------
module ahb_dst_port (
	input  logic                    clk,
	input  logic                    rst_n,
	input  cache_pkg::cache_state_t state,
	input  logic                    hit,
	input  logic                    dirty,
	input  ahb_pkg::addr_t          addr_dphase,
	input  ahb_pkg::addr_t          victim_addr,
	input  logic                    dst_hready_resp,
	input  ahb_pkg::data_t          dst_hrdata,
	output ahb_pkg::addr_t          dst_haddr,
	output logic                    dst_hwrite,
	output logic [1:0]              dst_htrans,
	output ahb_pkg::size_t          dst_hsize,
	output logic                    dst_hready,
	output logic                    dst_ready,
	output logic                    dphase_active,
	output ahb_pkg::data_t          fill_rdata
);
	import ahb_pkg::*;
	import cache_pkg::*;

	logic in_check;
	logic in_clean;
	logic in_fill;
	logic miss_issue;
	logic issue;

	assign in_check = state == READ_CHECK || state == WRITE_CHECK;
	assign in_clean = state == READ_CLEAN || state == WRITE_CLEAN;
	assign in_fill  = state == READ_FILL || state == WRITE_FILL;

	// Miss goes out from the check cycle, fill follows the write-back
	assign miss_issue = in_check && !hit;
	assign issue      = miss_issue || (in_clean && dst_hready_resp);

	assign dst_htrans = issue ? HTRANS_NSEQ : HTRANS_IDLE;
	assign dst_hwrite = miss_issue && dirty;
	assign dst_hsize  = issue ? HSIZE_WORD : '0;

	// Victim on write-back, requested word on fill
	assign dst_haddr = dst_hwrite ? victim_addr :
		{addr_dphase[W_ADDR-1:W_LANE_SEL], {W_LANE_SEL{1'b0}}};

	assign dst_hready = dst_hready_resp;
	assign dst_ready  = dst_hready_resp;

	// Open downstream data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dphase_active <= 1'b0;
		else if (dst_hready_resp)
			dphase_active <= dst_htrans == HTRANS_NSEQ;
	end

	// Fill word, kept for the cycle after the fill
	always_ff @(posedge clk) begin
		if (dst_hready_resp && in_fill)
			fill_rdata <= dst_hrdata;
	end

	// Back-pressure holds the downstream address
	assert property (@(posedge clk) disable iff (!rst_n)
		dphase_active && !dst_hready_resp |=> $stable(dst_haddr));

endmodule

/* design/cache_mem.sv */
// -------------------------------------------------------------------
// Direct-mapped tag store and byte-writable data store, both with
// registered read
// -------------------------------------------------------------------
module cache_mem (
	input  logic                clk,
	input  logic                rst_n,
	input  cache_pkg::index_t   t_index,
	input  cache_pkg::tag_t     t_tag,
	input  logic                t_ren,
	input  logic                t_wen,
	input  logic                t_wvalid,
	input  logic                t_wdirty,
	input  cache_pkg::index_t   d_index,
	input  logic                d_ren,
	input  ahb_pkg::lane_mask_t d_wen,
	input  ahb_pkg::data_t      wdata,
	output logic                hit,
	output logic                dirty,
	output ahb_pkg::addr_t      victim_addr,
	output ahb_pkg::data_t      rdata
);
	import ahb_pkg::*;
	import cache_pkg::*;

	tag_t               tag_mem [N_LINES];
	logic [N_LINES-1:0] valid_mem;
	logic [N_LINES-1:0] dirty_mem;
	data_t              data_mem [N_LINES];

	// Entry and query captured on a tag read
	tag_t   tag_q;
	tag_t   query_q;
	index_t index_q;
	logic   valid_q;
	logic   dirty_q;

	// -------------------------------------------------------------------
	// Tag store

	always_ff @(posedge clk) begin
		if (t_wen)
			tag_mem[t_index] <= t_tag;
		if (t_ren) begin
			tag_q   <= tag_mem[t_index];
			query_q <= t_tag;
			index_q <= t_index;
		end
	end

	// Status bits, the cache starts out empty
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_mem <= '0;
			dirty_mem <= '0;
			valid_q   <= 1'b0;
			dirty_q   <= 1'b0;
		end else begin
			if (t_wen) begin
				valid_mem[t_index] <= t_wvalid;
				dirty_mem[t_index] <= t_wdirty;
			end
			if (t_ren) begin
				valid_q <= valid_mem[t_index];
				dirty_q <= dirty_mem[t_index];
			end
		end
	end

	assign hit   = valid_q && tag_q == query_q;
	assign dirty = valid_q && dirty_q;

	// Word address of whatever line sits at the queried index
	assign victim_addr = {tag_q, index_q, {W_LANE_SEL{1'b0}}};

	// -------------------------------------------------------------------
	// Data store

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_LANES; i++)
			if (d_wen[i])
				data_mem[d_index][i*8 +: 8] <= wdata[i*8 +: 8];
		if (d_ren)
			rdata <= data_mem[d_index];
	end

endmodule

/* design/cache_ctrl.sv */
// -------------------------------------------------------------------
// Write-back cache FSM, store steering and upstream response
// -------------------------------------------------------------------
module cache_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    aphase_read,
	input  logic                    aphase_write,
	input  ahb_pkg::addr_t          addr_dphase,
	input  ahb_pkg::lane_mask_t     lane_mask_dphase,
	input  ahb_pkg::addr_t          src_haddr,
	input  ahb_pkg::data_t          src_hwdata,
	input  logic                    hit,
	input  logic                    dirty,
	input  ahb_pkg::data_t          rdata,
	input  logic                    dst_ready,
	input  logic                    dphase_active,
	input  ahb_pkg::data_t          fill_rdata,
	output cache_pkg::cache_state_t state,
	output logic                    src_hready_resp,
	output ahb_pkg::data_t          src_hrdata,
	output cache_pkg::index_t       t_index,
	output cache_pkg::tag_t         t_tag,
	output logic                    t_ren,
	output logic                    t_wen,
	output logic                    t_wvalid,
	output logic                    t_wdirty,
	output cache_pkg::index_t       d_index,
	output logic                    d_ren,
	output ahb_pkg::lane_mask_t     d_wen,
	output ahb_pkg::data_t          wdata
);
	import ahb_pkg::*;
	import cache_pkg::*;

	cache_state_t next_or_idle;
	logic         aphase;
	logic         dst_end;
	logic         stall_write;
	logic         in_check;
	logic         victim_rd;
	logic         modify_wen;
	logic         fill_wen;
	index_t       req_index;
	index_t       live_index;
	tag_t         req_tag;
	tag_t         live_tag;
	lane_mask_t   src_lanes;

	assign aphase  = aphase_read || aphase_write;
	assign dst_end = dst_ready && dphase_active;

	// Request in its data phase versus the one in its address phase
	assign req_index  = addr_dphase[W_LANE_SEL +: W_INDEX];
	assign req_tag    = addr_dphase[W_ADDR-1 -: W_TAG];
	assign live_index = src_haddr[W_LANE_SEL +: W_INDEX];
	assign live_tag   = src_haddr[W_ADDR-1 -: W_TAG];

	assign next_or_idle = aphase_read ? READ_CHECK : aphase_write ? WRITE_CHECK : IDLE;

	// -------------------------------------------------------------------
	// State machine

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			stall_write <= 1'b0;
		end else begin
			// Direction of a request that lands in the stall state
			stall_write <= aphase_write;
			case (state)
			IDLE:
				state <= next_or_idle;
			READ_CHECK: begin
				if (hit)
					state <= next_or_idle;
				else if (dirty)
					state <= READ_CLEAN;
				else
					state <= READ_FILL;
			end
			READ_CLEAN:
				if (dst_end)
					state <= READ_FILL;
			READ_FILL:
				if (dst_end)
					state <= READ_DONE;
			READ_DONE:
				// Fill write owns both stores, a new request is read next cycle
				state <= aphase ? WRITE2READ_STALL : IDLE;
			WRITE_CHECK: begin
				if (hit && !dirty)
					state <= WRITE_DONE;
				else if (hit && aphase_read)
					state <= WRITE2READ_STALL;
				else if (hit)
					state <= next_or_idle;
				else if (dirty)
					state <= WRITE_CLEAN;
				else
					state <= WRITE_FILL;
			end
			WRITE_CLEAN:
				if (dst_end)
					state <= WRITE_FILL;
			WRITE_FILL:
				if (dst_end)
					state <= WRITE_MODIFY;
			WRITE_MODIFY:
				state <= WRITE_DONE;
			WRITE_DONE:
				state <= next_or_idle;
			WRITE2READ_STALL:
				state <= stall_write ? WRITE_CHECK : READ_CHECK;
			default:
				state <= IDLE;
			endcase
		end
	end

	// -------------------------------------------------------------------
	// Store steering

	assign in_check   = state == READ_CHECK || state == WRITE_CHECK;
	// Victim data reread so the write-back has it on the data port
	assign victim_rd  = in_check && !hit && dirty;
	assign modify_wen = (state == WRITE_CHECK && hit) || state == WRITE_MODIFY;
	assign fill_wen   = state == READ_DONE;

	// Tag store, a hit on a dirty line leaves the tag alone
	assign t_wen    = (modify_wen && !(state == WRITE_CHECK && dirty)) || fill_wen;
	assign t_wvalid = t_wen;
	assign t_wdirty = !fill_wen;
	assign t_ren    = (aphase && !t_wen) || state == WRITE2READ_STALL;
	assign t_index  = (t_wen || state == WRITE2READ_STALL) ? req_index : live_index;
	assign t_tag    = (t_wen || state == WRITE2READ_STALL) ? req_tag : live_tag;

	// Whole line written after a fill, addressed lanes on a hit
	assign d_wen = (fill_wen || state == WRITE_MODIFY) ? '1 :
		modify_wen ? lane_mask_dphase : '0;
	assign d_ren = (aphase_read && d_wen == '0) || state == WRITE2READ_STALL || victim_rd;
	assign d_index = (d_wen != '0 || state == WRITE2READ_STALL || victim_rd) ?
		req_index : live_index;

	// Upstream lanes win over the fill word
	assign src_lanes = fill_wen ? '0 : lane_mask_dphase;

	always_comb begin
		for (int i = 0; i < N_LANES; i++)
			wdata[i*8 +: 8] = src_lanes[i] ? src_hwdata[i*8 +: 8] : fill_rdata[i*8 +: 8];
	end

	// -------------------------------------------------------------------
	// Upstream response

	assign src_hrdata = state == READ_DONE ? fill_rdata : rdata;

	assign src_hready_resp = state == IDLE ||
		(state == READ_CHECK && hit) ||
		state == READ_DONE ||
		(state == WRITE_CHECK && hit && dirty) ||
		state == WRITE_DONE;

	// Store writes follow a tag hit or a fill that just ended,
	// never under an open downstream transfer
	assert property (@(posedge clk) disable iff (!rst_n)
		(t_wen || |d_wen) |-> !(dphase_active && !dst_ready) &&
			(hit || $past(dst_end)));

endmodule

/* design/ahb_src_port.sv */
// -------------------------------------------------------------------
// Upstream AHB-Lite slave side, decodes and captures address phases
// and builds the byte-lane mask for the data phase
// -------------------------------------------------------------------
module ahb_src_port (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                src_hready,
	input  logic [1:0]          src_htrans,
	input  logic                src_hwrite,
	input  ahb_pkg::addr_t      src_haddr,
	input  ahb_pkg::size_t      src_hsize,
	output logic                aphase_read,
	output logic                aphase_write,
	output ahb_pkg::addr_t      addr_dphase,
	output ahb_pkg::lane_mask_t lane_mask_dphase
);
	import ahb_pkg::*;

	logic       aphase;
	size_t      size_dphase;
	lane_mask_t size_mask;

	// -------------------------------------------------------------------
	// Address phase decode

	// Only NONSEQ is ever issued upstream, no bursts
	assign aphase       = src_hready && src_htrans == HTRANS_NSEQ;
	assign aphase_read  = aphase && !src_hwrite;
	assign aphase_write = aphase && src_hwrite;

	// Held for the whole data phase, no new phase while hready is low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_dphase <= '0;
			size_dphase <= '0;
		end else if (aphase) begin
			addr_dphase <= src_haddr;
			size_dphase <= src_hsize;
		end
	end

	// -------------------------------------------------------------------
	// Byte lanes

	// Lanes of the transfer size, at offset zero
	always_comb begin
		case (size_dphase)
		3'd0:    size_mask = lane_mask_t'(1);
		3'd1:    size_mask = lane_mask_t'(3);
		default: size_mask = '1;
		endcase
	end

	// Moved up to the addressed byte
	assign lane_mask_dphase = size_mask << addr_dphase[W_LANE_SEL-1:0];

	// Accepted transfers fit in one word at a natural boundary
	assert property (@(posedge clk) disable iff (!rst_n)
		aphase |-> src_hsize <= HSIZE_WORD &&
			(int'(src_haddr[W_LANE_SEL-1:0]) % (1 << src_hsize)) == 0);

endmodule

/* design/cache_pkg.sv */
// -------------------------------------------------------------------
// Cache geometry and controller states
// -------------------------------------------------------------------
package cache_pkg;

	// One bus word per line
	localparam int N_LINES = 64;
	localparam int W_INDEX = $clog2(N_LINES);
	localparam int W_TAG   = ahb_pkg::W_ADDR - W_INDEX - ahb_pkg::W_LANE_SEL;

	typedef logic [W_INDEX-1:0] index_t;
	typedef logic [W_TAG-1:0]   tag_t;

	typedef enum logic [3:0] {
		// No upstream data phase open
		IDLE,
		// Tag status and read data valid
		READ_CHECK,
		// Dirty victim written back downstream
		READ_CLEAN,
		// Line fetched from downstream
		READ_FILL,
		// Fill data returned and written into the stores
		READ_DONE,
		WRITE_CHECK,
		WRITE_CLEAN,
		WRITE_FILL,
		// Fill data merged with the upstream write lanes
		WRITE_MODIFY,
		WRITE_DONE,
		// Stores were busy when a request arrived, read them again here
		WRITE2READ_STALL
	} cache_state_t;

endpackage

/* design/ahb_pkg.sv */
// -------------------------------------------------------------------
// AHB-Lite bus definitions shared by the upstream and downstream sides
// -------------------------------------------------------------------
package ahb_pkg;

	// Bus widths
	localparam int W_ADDR     = 32;
	localparam int W_DATA     = 32;
	localparam int N_LANES    = W_DATA / 8;
	localparam int W_LANE_SEL = $clog2(N_LANES);

	typedef logic [W_ADDR-1:0]  addr_t;
	typedef logic [W_DATA-1:0]  data_t;
	typedef logic [N_LANES-1:0] lane_mask_t;
	typedef logic [2:0]         size_t;

	// Transfer type codes, only single transfers are used
	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NSEQ = 2'b10;

	// One full bus word
	localparam size_t HSIZE_WORD = size_t'(W_LANE_SEL);

endpackage
